// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_spi_init -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_spi_init); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

// ==== flist.f ====
spi_seq_pkg.sv
spi_frame_pkg.sv
spi_tbl.sv
spi_cmd.sv
spi_master.sv
spi_init_top.sv
tb_clkgen.sv
tb_spi_init.sv

// ==== spi_cmd.sv ====
`default_nettype none

module spi_cmd (
    input  var logic                      clk,
    input  var logic                      reset,
    input  var logic                      enable,

    output var spi_seq_pkg::tbl_addr_t    tbl_addr,
    input  var spi_seq_pkg::tbl_op_t      tbl_op,
    input  var spi_seq_pkg::tbl_data_t    tbl_data,

    output var spi_frame_pkg::reg_addr_t  cmd_addr,
    output var logic                      cmd_we,
    output var spi_frame_pkg::reg_data_t  cmd_wdata,
    output var logic                      cmd_valid,
    input  var logic                      cmd_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_cmd,
        st_wait
    } state_t;

    state_t                 state;
    spi_seq_pkg::tbl_data_t payload;  // held frame, or wait down-counter

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            tbl_addr  <= '0;
            cmd_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (enable) begin
                        case (tbl_op)
                            spi_seq_pkg::op_cmd: begin
                                state     <= st_cmd;
                                tbl_addr  <= tbl_addr + 1'b1;
                                cmd_valid <= 1'b1;
                            end
                            spi_seq_pkg::op_wait: begin
                                state    <= st_wait;
                                tbl_addr <= tbl_addr + 1'b1;
                            end
                            spi_seq_pkg::op_jump: begin
                                tbl_addr <= spi_seq_pkg::tbl_addr_t'(tbl_data);
                            end
                            default: ;  // halt
                        endcase
                    end
                end

                st_cmd: begin
                    if (cmd_valid && cmd_ready) begin
                        state     <= st_idle;
                        cmd_valid <= 1'b0;
                    end
                end

                st_wait: begin
                    if (payload == '0) begin
                        state <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    // payload latches the entry on issue, counts down in wait
    always_ff @(posedge clk) begin
        if (state == st_idle && enable &&
            (tbl_op == spi_seq_pkg::op_cmd || tbl_op == spi_seq_pkg::op_wait)) begin
            payload <= tbl_data;
        end else if (state == st_wait) begin
            payload <= payload - 1'b1;
        end
    end

    assign {cmd_addr, cmd_we, cmd_wdata} = payload;

    // an offered frame is not withdrawn
    assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid);

    assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> $stable({cmd_addr, cmd_we, cmd_wdata}));

endmodule

`default_nettype wire

// ==== spi_frame_pkg.sv ====
`default_nettype none

package spi_frame_pkg;

    localparam int REG_ADDR_BITS = 9;
    localparam int REG_DATA_BITS = 16;

    // sclk periods per frame: address, write flag, data
    localparam int FRAME_BITS = REG_ADDR_BITS + 1 + REG_DATA_BITS;

    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [REG_DATA_BITS-1:0] reg_data_t;

    // {addr, we, data}, msb goes out first
    typedef logic [FRAME_BITS-1:0] frame_t;

endpackage

`default_nettype wire

// ==== spi_init_stim.txt ====
# expected spi traffic of the init program, in bus order
# F <reg addr hex> <write flag> <data hex>   one frame, read frames carry data 0000
# P <cycles>   enable low for that long, from reset or from the end of the frame above
# W <cycles>   a table wait follows the frame above

P 50

# soft reset
F 000 1 0001
F 010 1 1234

# pause while the sequencer sits in the wait entry
P 60
W 200

F 011 1 abcd

# read-backs of the two written registers
F 010 0 0000
F 011 0 0000

# jump skips the writes to 1ff and 1fe
F 020 1 8000

# table halts after this

// ==== spi_init_top.sv ====
`default_nettype none

module spi_init_top #(
    parameter int CLK_DIV = 2
) (
    input  var logic                      clk,
    input  var logic                      reset,
    input  var logic                      enable,

    output var logic                      sclk,
    output var logic                      cs_n,
    output var logic                      mosi,
    input  var logic                      miso,

    output var spi_frame_pkg::reg_data_t  rd_data,
    output var logic                      rd_valid
);

    spi_seq_pkg::tbl_addr_t    tbl_addr;
    spi_seq_pkg::tbl_op_t      tbl_op;
    spi_seq_pkg::tbl_data_t    tbl_data;

    spi_frame_pkg::reg_addr_t  cmd_addr;
    logic                      cmd_we;
    spi_frame_pkg::reg_data_t  cmd_wdata;
    logic                      cmd_valid;
    logic                      cmd_ready;

    spi_tbl u_tbl (
        .addr (tbl_addr),
        .op   (tbl_op),
        .data (tbl_data)
    );

    spi_cmd u_cmd (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .tbl_addr  (tbl_addr),
        .tbl_op    (tbl_op),
        .tbl_data  (tbl_data),
        .cmd_addr  (cmd_addr),
        .cmd_we    (cmd_we),
        .cmd_wdata (cmd_wdata),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

    spi_master #(
        .CLK_DIV (CLK_DIV)
    ) u_master (
        .clk       (clk),
        .reset     (reset),
        .cmd_addr  (cmd_addr),
        .cmd_we    (cmd_we),
        .cmd_wdata (cmd_wdata),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

endmodule

`default_nettype wire

// ==== spi_master.sv ====
`default_nettype none

module spi_master #(
    parameter int CLK_DIV = 2  // half sclk period in clk cycles
) (
    input  var logic                      clk,
    input  var logic                      reset,

    input  var spi_frame_pkg::reg_addr_t  cmd_addr,
    input  var logic                      cmd_we,
    input  var spi_frame_pkg::reg_data_t  cmd_wdata,
    input  var logic                      cmd_valid,
    output var logic                      cmd_ready,

    output var logic                      sclk,
    output var logic                      cs_n,
    output var logic                      mosi,
    input  var logic                      miso,

    output var spi_frame_pkg::reg_data_t  rd_data,
    output var logic                      rd_valid
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);
    localparam int BIT_W = $clog2(spi_frame_pkg::FRAME_BITS + 1);
    localparam int RD_LAT = CLK_DIV * (2 * spi_frame_pkg::FRAME_BITS + 1) + 1;

    typedef enum logic [1:0] {
        ms_idle,
        ms_shift,
        ms_tail
    } state_t;

    state_t                 state;
    logic [DIV_W-1:0]       div_cnt;
    logic [BIT_W-1:0]       bit_cnt;  // falling edges so far
    logic                   div_end;
    logic                   is_read;
    logic                   miso_q;
    spi_frame_pkg::frame_t  sreg;

    assign cmd_ready = (state == ms_idle);
    assign div_end   = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign mosi      = ~cs_n & sreg[spi_frame_pkg::FRAME_BITS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ms_idle;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            sclk     <= 1'b0;
            cs_n     <= 1'b1;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            case (state)
                ms_idle: begin
                    if (cmd_valid) begin
                        state   <= ms_shift;
                        cs_n    <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end

                ms_shift: begin
                    div_cnt <= div_end ? '0 : div_cnt + 1'b1;
                    if (div_end) begin
                        if (sclk) begin
                            sclk    <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (bit_cnt == BIT_W'(spi_frame_pkg::FRAME_BITS)) begin
                            state    <= ms_tail;
                            cs_n     <= 1'b1;
                            rd_valid <= is_read;
                        end else begin
                            sclk <= 1'b1;
                        end
                    end
                end

                ms_tail: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_end) begin
                        state <= ms_idle;
                    end
                end

                default: state <= ms_idle;
            endcase
        end
    end

    // frame data path: load on accept, sample on rise, shift on fall
    always_ff @(posedge clk) begin
        if (state == ms_idle && cmd_valid) begin
            sreg    <= {cmd_addr, cmd_we, cmd_wdata};
            is_read <= ~cmd_we;
        end else if (state == ms_shift && div_end) begin
            if (sclk) begin
                sreg <= {sreg[spi_frame_pkg::FRAME_BITS-2:0], miso_q};
            end else begin
                miso_q <= miso;
            end
        end
        if (state == ms_shift && div_end && !sclk &&
            bit_cnt == BIT_W'(spi_frame_pkg::FRAME_BITS)) begin
            rd_data <= sreg[spi_frame_pkg::REG_DATA_BITS-1:0];  // last 16 rises
        end
    end

    assert property (@(posedge clk) disable iff (reset) cs_n |-> !sclk);

    // a result belongs to the read frame accepted a fixed time before
    assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> $past(cmd_valid && cmd_ready && !cmd_we, RD_LAT));

endmodule

`default_nettype wire

// ==== spi_seq_pkg.sv ====
`default_nettype none

package spi_seq_pkg;

    localparam int TBL_ADDR_BITS = 8;
    localparam int TBL_DATA_BITS = 26;

    // index into the command table
    typedef logic [TBL_ADDR_BITS-1:0] tbl_addr_t;

    // entry payload: frame, wait count or jump target depending on the op
    typedef logic [TBL_DATA_BITS-1:0] tbl_data_t;

    typedef enum logic [1:0] {
        op_cmd  = 2'd0,  // issue one spi frame
        op_wait = 2'd1,  // stall for payload+1 cycles
        op_jump = 2'd2,  // load table address from payload
        op_halt = 2'd3   // stay here
    } tbl_op_t;

endpackage

`default_nettype wire

// ==== spi_tbl.sv ====
`default_nettype none

module spi_tbl (
    input  var spi_seq_pkg::tbl_addr_t addr,
    output var spi_seq_pkg::tbl_op_t   op,
    output var spi_seq_pkg::tbl_data_t data
);

    function automatic spi_frame_pkg::frame_t wr(input spi_frame_pkg::reg_addr_t a,
                                                 input spi_frame_pkg::reg_data_t d);
        return {a, 1'b1, d};
    endfunction

    function automatic spi_frame_pkg::frame_t rd(input spi_frame_pkg::reg_addr_t a);
        return {a, 1'b0, 16'h0000};
    endfunction

    // init program
    always_comb begin
        op   = spi_seq_pkg::op_halt;
        data = '0;
        case (addr)
            8'd0: begin op = spi_seq_pkg::op_cmd; data = wr(9'h000, 16'h0001); end  // soft reset
            8'd1: begin op = spi_seq_pkg::op_cmd; data = wr(9'h010, 16'h1234); end
            8'd2: begin
                op   = spi_seq_pkg::op_wait;       // let the part settle
                data = spi_seq_pkg::tbl_data_t'(200);
            end
            8'd3: begin op = spi_seq_pkg::op_cmd; data = wr(9'h011, 16'habcd); end
            8'd4: begin op = spi_seq_pkg::op_cmd; data = rd(9'h010); end
            8'd5: begin op = spi_seq_pkg::op_cmd; data = rd(9'h011); end
            8'd6: begin
                op   = spi_seq_pkg::op_jump;       // skip the two dummies below
                data = spi_seq_pkg::tbl_data_t'(9);
            end
            8'd7: begin op = spi_seq_pkg::op_cmd; data = wr(9'h1ff, 16'hdead); end
            8'd8: begin op = spi_seq_pkg::op_cmd; data = wr(9'h1fe, 16'hbeef); end
            8'd9: begin op = spi_seq_pkg::op_cmd; data = wr(9'h020, 16'h8000); end  // enable
            default: begin
                op   = spi_seq_pkg::op_halt;
                data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
    output var logic clk,
    output var logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // period 10
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_spi_init.sv ====
`default_nettype none

module tb_spi_init;

    localparam int CLK_DIV = 2;
    localparam int MAX_LINES = 64;

    logic clk, reset, enable, miso;
    logic sclk, cs_n, mosi, rd_valid;
    spi_frame_pkg::reg_data_t rd_data;

    // expected frames and directives from the stim file
    spi_frame_pkg::reg_addr_t exp_addr [MAX_LINES];
    logic                     exp_we [MAX_LINES];
    spi_frame_pkg::reg_data_t exp_data [MAX_LINES];
    int          pause_after [MAX_LINES];
    int          wait_after [MAX_LINES];
    int          fall_cyc [MAX_LINES];
    int          n_frames, n_reads, wait_total, pause_total, limit;

    spi_frame_pkg::reg_data_t regs [512];  // peripheral register model
    spi_frame_pkg::frame_t    rx;
    spi_frame_pkg::reg_addr_t cur_addr, last_addr;
    logic        cur_we, last_we, miso_next, cs_prev, sclk_prev;
    int          bit_n, fall_n, frames_seen, rd_count, pause_left, cyc;

    tb_clkgen u_clkgen (.clk(clk), .reset(reset));

    spi_init_top #(.CLK_DIV(CLK_DIV)) dut (
        .clk(clk), .reset(reset), .enable(enable),
        .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .rd_data(rd_data), .rd_valid(rd_valid)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic read_stim();
        int fd, cnt;
        string line;
        byte k;
        logic [31:0] a, w, d;
        fd = $fopen("spi_init_stim.txt", "r");
        if (fd == 0) fail_run("cannot open spi_init_stim.txt");
        while ($fgets(line, fd) > 0) begin
            cnt = $sscanf(line, "%c", k);
            if (cnt == 1 && k == "F") begin
                cnt = $sscanf(line, "%c %h %h %h", k, a, w, d);
                exp_addr[n_frames] = a[8:0];
                exp_we[n_frames] = w[0];
                exp_data[n_frames] = d[15:0];
                if (w[0] == 1'b0) n_reads++;
                n_frames++;
            end else if (cnt == 1 && (k == "P" || k == "W")) begin
                cnt = $sscanf(line, "%c %d", k, a);
                if (k == "W") begin
                    wait_after[n_frames-1] = int'(a);
                    wait_total += int'(a);
                end else begin
                    // a pause before any frame applies right after reset
                    if (n_frames == 0) pause_left += int'(a);
                    else pause_after[n_frames-1] += int'(a);
                    pause_total += int'(a);
                end
            end
        end
        $fclose(fd);
    endtask

    // bus monitor, peripheral model and enable pacing
    always @(posedge clk) begin
        if (!reset) begin
            cyc++;
            if (pause_left > 0) pause_left--;
            if (cs_prev && !cs_n) begin
                if (pause_left > 0) fail_run("a frame started during an enable pause");
                if (frames_seen >= n_frames) begin
                    fail_run("a frame started after the last expected one");
                end
                if (frames_seen > 0 && wait_after[frames_seen-1] > 0 &&
                    cyc - fall_cyc[frames_seen-1] < wait_after[frames_seen-1]) begin
                    fail_run("frame after a table wait started too early");
                end
                fall_cyc[frames_seen] = cyc;
                frames_seen++;
                bit_n = 0;
                fall_n = 0;
                rx = '0;
            end
            if (!cs_n && sclk && !sclk_prev) begin  // rising sclk
                rx = {rx[24:0], mosi};
                bit_n++;
                if (bit_n == 10) begin
                    cur_addr = rx[9:1];
                    cur_we = rx[0];
                end
            end
            if (!cs_n && !sclk && sclk_prev) begin  // falling sclk
                fall_n++;
                miso_next = 1'b0;
                if (!cur_we && fall_n >= 10 && fall_n <= 25) begin
                    miso_next = regs[cur_addr][25-fall_n];
                end
            end
            if (!cs_prev && cs_n) begin
                check("frame bit count", bit_n, 26);
                check("frame addr", 32'(rx[25:17]), 32'(exp_addr[frames_seen-1]));
                check("frame write flag", 32'(rx[16]), 32'(exp_we[frames_seen-1]));
                check("frame data", 32'(rx[15:0]), 32'(exp_data[frames_seen-1]));
                last_addr = rx[25:17];
                last_we = rx[16];
                if (last_we) regs[last_addr] = rx[15:0];
                if (pause_after[frames_seen-1] > 0) pause_left = pause_after[frames_seen-1];
                miso_next = 1'b0;
            end
            if (rd_valid) begin
                rd_count++;
                check("write flag of frame before rd_valid", 32'(last_we), 32'd0);
                check("rd_data", 32'(rd_data), 32'(regs[last_addr]));
            end
            cs_prev = cs_n;
            sclk_prev = sclk;
            #1;
            enable = (pause_left == 0);
            miso = miso_next;
        end
    end

    initial begin
        enable = 1'b0;
        miso = 1'b0;
        miso_next = 1'b0;
        cs_prev = 1'b1;
        sclk_prev = 1'b0;
        cur_we = 1'b1;
        last_we = 1'b1;
        last_addr = '0;
        for (int i = 0; i < MAX_LINES; i++) begin
            pause_after[i] = 0;
            wait_after[i] = 0;
        end
        for (int i = 0; i < 512; i++) regs[i] = 16'(i * 40503) ^ 16'h5a5a;
        read_stim();
        limit = n_frames * (spi_frame_pkg::FRAME_BITS + 4) * 2 * CLK_DIV
                + wait_total + pause_total + 1000;
        fork
            begin
                repeat (limit) @(posedge clk);
                fail_run("timed out waiting for the init program to finish");
            end
        join_none
        wait (frames_seen == n_frames && cs_n && !reset);
        repeat (500) @(posedge clk);  // halt keeps the bus quiet
        check("rd_valid count", rd_count, n_reads);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
